// ==== hw/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch address width, byte addressed
`define ICACHE_ADDR_W 32

// associativity and number of sets
`define ICACHE_WAYS 4
`define ICACHE_SETS 16

// one line holds four fetch words
`define ICACHE_LINE_W 128
`define ICACHE_WORD_W 32

// width of the random replacement register
`define ICACHE_LFSR_W 8

// derived widths
`define ICACHE_INDEX_W $clog2(`ICACHE_SETS)
// byte offset inside a line
`define ICACHE_OFFSET_W $clog2(`ICACHE_LINE_W / 8)
`define ICACHE_TAG_W (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)
`define ICACHE_WAY_IDX_W $clog2(`ICACHE_WAYS)

`endif

// ==== hw/icache_pkg.sv ====
`include "icache_consts.svh"

package icache_pkg;

  // plain vectors with a meaning of their own
  typedef logic [`ICACHE_ADDR_W-1:0]                       addr_t;
  typedef logic [`ICACHE_TAG_W-1:0]                        tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0]                      set_idx_t;
  typedef logic [$clog2(`ICACHE_LINE_W/`ICACHE_WORD_W)-1:0] word_sel_t;
  typedef logic [`ICACHE_WORD_W-1:0]                       word_t;
  typedef logic [`ICACHE_LINE_W-1:0]                       line_t;
  typedef logic [`ICACHE_WAYS-1:0]                         way_oh_t;
  typedef logic [`ICACHE_WAY_IDX_W-1:0]                    way_idx_t;

  // fetch port
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    word_t data;
    // echo of the accepted address
    addr_t addr;
  } fetch_rsp_t;

  // refill port, whole lines only
  typedef struct packed {
    logic [`ICACHE_ADDR_W-`ICACHE_OFFSET_W-1:0] line_addr;
  } mem_req_t;

  typedef struct packed {
    line_t data;
  } mem_rtrn_t;

  // write command into the tag, valid and data arrays
  typedef struct packed {
    set_idx_t set;
    way_oh_t  way_mask;
    tag_t     tag;
    line_t    line;
    logic     valid;
    // low for flush writes, which touch tag and valid only
    logic     data_we;
  } array_wr_t;

  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } ctrl_state_e;

endpackage

// ==== hw/icache_arrays.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_arrays import icache_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     read_en_i,
  input  set_idx_t                 read_set_i,
  input  logic                     wr_en_i,
  input  array_wr_t                wr_i,
  output tag_t  [`ICACHE_WAYS-1:0] tags_o,
  output way_oh_t                  valid_o,
  output line_t [`ICACHE_WAYS-1:0] lines_o
);

  // valid bits of all ways, one word per set
  way_oh_t valid_q [`ICACHE_SETS];

  ////////////////////////////////////////////////////////////////////////////
  // tag and data storage, one bank per way
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_way
    tag_t  tag_mem  [`ICACHE_SETS];
    line_t line_mem [`ICACHE_SETS];
    tag_t  tag_rd_q;
    line_t line_rd_q;

    always_ff @(posedge clk_i) begin : p_mem
      if (wr_en_i && wr_i.way_mask[w]) begin
        tag_mem[wr_i.set] <= wr_i.tag;
        // flush writes leave the line contents alone
        if (wr_i.data_we) begin
          line_mem[wr_i.set] <= wr_i.line;
        end
      end
      // registered read port, holds when not enabled
      if (read_en_i) begin
        tag_rd_q  <= tag_mem[read_set_i];
        line_rd_q <= line_mem[read_set_i];
      end
    end

    assign tags_o[w]  = tag_rd_q;
    assign lines_o[w] = line_rd_q;
  end

  ////////////////////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
    if (!rst_ni) begin
      valid_q <= '{default: '0};
      valid_o <= '0;
    end else begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        if (wr_en_i && wr_i.way_mask[w]) begin
          valid_q[wr_i.set][w] <= wr_i.valid;
        end
      end
      if (read_en_i) begin
        valid_o <= valid_q[read_set_i];
      end
    end
  end

  // only flush writes may cover several ways at once
  a_single_way_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_en_i && !$onehot0(wr_i.way_mask)) |-> !wr_i.data_we)
    else $error("icache_arrays: line write to mask %b", wr_i.way_mask);

endmodule

// ==== hw/icache_lookup.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_lookup import icache_pkg::*; (
  input  tag_t  [`ICACHE_WAYS-1:0] tags_i,
  input  way_oh_t                  valid_i,
  input  line_t [`ICACHE_WAYS-1:0] lines_i,
  input  tag_t                     lookup_tag_i,
  input  word_sel_t                word_sel_i,
  output logic                     hit_o,
  output word_t                    hit_word_o
);

  way_oh_t  hit_vec;
  way_idx_t hit_idx;
  line_t    hit_line;

  // per-way compare, invalid ways never hit
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : gen_cmp
    assign hit_vec[w] = valid_i[w] && (tags_i[w] == lookup_tag_i);
  end

  assign hit_o = |hit_vec;

  // binary encode of the hitting way
  // lowest index wins, though at most one should be set
  always_comb begin : p_hit_enc
    hit_idx = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_idx = way_idx_t'(w);
      end
    end
  end

  // word select inside the hitting line
  assign hit_line   = lines_i[hit_idx];
  assign hit_word_o = hit_line[word_sel_i * `ICACHE_WORD_W +: `ICACHE_WORD_W];

  // refills only happen on a miss, so a tag lives in one way of a set
  always_comb begin : p_hit_check
    a_hit_onehot: assert final ($isunknown(hit_vec) || $onehot0(hit_vec))
      else $error("icache_lookup: several ways hit, vector %b", hit_vec);
  end

endmodule

// ==== hw/icache_repl.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_repl import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  way_oh_t valid_i,
  input  logic    refill_done_i,
  output way_oh_t victim_oh_o
);

  logic [`ICACHE_LFSR_W-1:0] lfsr_q;
  logic                      lfsr_fb;
  logic                      any_invalid;
  way_idx_t                  inv_idx;
  way_idx_t                  victim_idx;

  ////////////////////////////////////////////////////////////////////////////
  // random way source
  ////////////////////////////////////////////////////////////////////////////

  // x^8 + x^6 + x^5 + x^4 + 1, maximal length
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      // any nonzero seed
      lfsr_q <= `ICACHE_LFSR_W'(1);
    end else if (refill_done_i) begin
      lfsr_q <= {lfsr_q[`ICACHE_LFSR_W-2:0], lfsr_fb};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // victim choice
  ////////////////////////////////////////////////////////////////////////////

  assign any_invalid = ~&valid_i;

  // lowest numbered free way
  always_comb begin : p_first_inv
    inv_idx = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_idx = way_idx_t'(w);
      end
    end
  end

  // random pick only once the set is full
  assign victim_idx  = any_invalid ? inv_idx : lfsr_q[`ICACHE_WAY_IDX_W-1:0];
  assign victim_oh_o = way_oh_t'(1) << victim_idx;

  // victim is a single way
  // while any way is free it is the lowest free one
  a_victim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot(victim_oh_o) &&
    (!any_invalid || (((victim_oh_o & valid_i) == '0) &&
                      (((victim_oh_o - 1'b1) & ~valid_i) == '0))))
    else $error("icache_repl: victim mask %b for valid bits %b", victim_oh_o, valid_i);

endmodule

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ctrl import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       fetch_req_valid_i,
  input  fetch_req_t fetch_req_i,
  input  logic       fetch_rsp_ready_i,
  input  logic       mem_req_ready_i,
  input  logic       mem_rtrn_valid_i,
  input  mem_rtrn_t  mem_rtrn_i,
  input  logic       flush_i,
  input  logic       hit_i,
  input  word_t      hit_word_i,
  input  way_oh_t    victim_oh_i,
  output logic       fetch_req_ready_o,
  output logic       fetch_rsp_valid_o,
  output fetch_rsp_t fetch_rsp_o,
  output logic       mem_req_valid_o,
  output mem_req_t   mem_req_o,
  output logic       miss_o,
  output logic       busy_o,
  output logic       read_en_o,
  output set_idx_t   read_set_o,
  output logic       wr_en_o,
  output array_wr_t  wr_o,
  output tag_t       lookup_tag_o,
  output word_sel_t  word_sel_o,
  output logic       refill_done_o
);

  ctrl_state_e state_d, state_q;

  // accepted request and its fields
  addr_t     addr_q;
  tag_t      req_tag;
  set_idx_t  req_set;
  word_sel_t req_word;

  // high in the second lookup cycle, when array data is fresh
  logic      cmp_q;
  logic      decide;
  logic      refill_fire;
  logic      req_fire;

  // flush bookkeeping
  logic      flush_pend_q;
  logic      flush_done;
  set_idx_t  flush_cnt_q;

  way_oh_t    victim_q;
  logic       miss_q;
  fetch_rsp_t rsp_q;
  logic       rsp_load;
  word_t      rsp_data;
  word_t      rtrn_word;

  ////////////////////////////////////////////////////////////////////////////
  // address split
  ////////////////////////////////////////////////////////////////////////////

  assign req_tag  = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
  assign req_set  = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
  // word index sits just above the two byte bits
  assign req_word = addr_q[`ICACHE_OFFSET_W-$bits(word_sel_t) +: $bits(word_sel_t)];

  assign lookup_tag_o = req_tag;
  assign word_sel_o   = req_word;

  // addressed word straight out of the refill line
  assign rtrn_word = mem_rtrn_i.data[req_word * `ICACHE_WORD_W +: `ICACHE_WORD_W];

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  assign req_fire    = fetch_req_valid_i && fetch_req_ready_o;
  assign decide      = (state_q == LOOKUP) && cmp_q;
  assign refill_fire = (state_q == REFILL_WAIT) && mem_rtrn_valid_i;
  assign flush_done  = (state_q == FLUSH) && (flush_cnt_q == set_idx_t'(`ICACHE_SETS - 1));

  always_comb begin : p_fsm
    state_d = state_q;
    unique case (state_q)
      // one set per cycle, valid bits cleared
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
        end
      end
      // pending flush wins over new requests
      IDLE: begin
        if (flush_pend_q) begin
          state_d = FLUSH;
        end else if (fetch_req_valid_i) begin
          state_d = LOOKUP;
        end
      end
      // first cycle reads the set, second compares
      LOOKUP: begin
        if (cmp_q) begin
          state_d = hit_i ? RESPOND : REFILL_REQ;
        end
      end
      REFILL_REQ: begin
        if (mem_req_ready_i) begin
          state_d = REFILL_WAIT;
        end
      end
      REFILL_WAIT: begin
        if (mem_rtrn_valid_i) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (fetch_rsp_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  // handshake outputs
  assign fetch_req_ready_o = (state_q == IDLE) && !flush_pend_q;
  assign fetch_rsp_valid_o = (state_q == RESPOND);
  assign fetch_rsp_o       = rsp_q;
  assign mem_req_valid_o   = (state_q == REFILL_REQ);
  assign mem_req_o         = '{line_addr: {req_tag, req_set}};
  assign miss_o            = miss_q;
  assign busy_o            = (state_q != IDLE);

  // array read in the first lookup cycle
  assign read_en_o  = (state_q == LOOKUP) && !cmp_q;
  assign read_set_o = req_set;

  // flush clears all ways of a set, refill fills the latched victim
  assign wr_en_o          = (state_q == FLUSH) || refill_fire;
  assign wr_o.set         = (state_q == FLUSH) ? flush_cnt_q : req_set;
  assign wr_o.way_mask    = (state_q == FLUSH) ? '1 : victim_q;
  assign wr_o.tag         = req_tag;
  assign wr_o.line        = mem_rtrn_i.data;
  assign wr_o.valid       = (state_q != FLUSH);
  assign wr_o.data_we     = (state_q != FLUSH);
  assign refill_done_o    = refill_fire;

  // response from the hit way or from the refill line
  assign rsp_load = (decide && hit_i) || refill_fire;
  assign rsp_data = refill_fire ? rtrn_word : hit_word_i;

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_regs
    if (!rst_ni) begin
      state_q      <= FLUSH;
      cmp_q        <= 1'b0;
      miss_q       <= 1'b0;
      flush_pend_q <= 1'b0;
      flush_cnt_q  <= '0;
    end else begin
      state_q      <= state_d;
      cmp_q        <= read_en_o;
      // one pulse per refill request, first cycle of REFILL_REQ
      miss_q       <= decide && !hit_i;
      // a new flush_i is kept, taking the flush clears it
      flush_pend_q <= flush_i || (flush_pend_q && (state_q != IDLE));
      if (state_q == FLUSH) begin
        // wraps to zero after the last set
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin : p_payload_regs
    if (req_fire) begin
      addr_q <= fetch_req_i.addr;
    end
    // victim is chosen from the valid bits of the looked up set
    if (decide) begin
      victim_q <= victim_oh_i;
    end
    if (rsp_load) begin
      rsp_q.data <= rsp_data;
      rsp_q.addr <= addr_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, LOOKUP, REFILL_REQ, REFILL_WAIT, RESPOND})
    else $error("icache_ctrl: illegal state %0h", state_q);

  // the memory side only returns what was requested
  a_rtrn_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rtrn_valid_i |-> (state_q == REFILL_WAIT))
    else $error("icache_ctrl: refill return outside REFILL_WAIT");

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_top import icache_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  // fetch request
  input  logic       fetch_req_valid_i,
  output logic       fetch_req_ready_o,
  input  fetch_req_t fetch_req_i,
  // fetch response
  output logic       fetch_rsp_valid_o,
  input  logic       fetch_rsp_ready_i,
  output fetch_rsp_t fetch_rsp_o,
  // line refill request
  output logic       mem_req_valid_o,
  input  logic       mem_req_ready_i,
  output mem_req_t   mem_req_o,
  // refill return, never stalled
  input  logic       mem_rtrn_valid_i,
  input  mem_rtrn_t  mem_rtrn_i,
  // control and status
  input  logic       flush_i,
  output logic       miss_o,
  output logic       busy_o
);

  // array access from the controller
  logic      rd_en;
  set_idx_t  rd_set;
  logic      wr_en;
  array_wr_t wr;

  // registered array read data, all ways of one set
  tag_t  [`ICACHE_WAYS-1:0] way_tags;
  way_oh_t                  way_valid;
  line_t [`ICACHE_WAYS-1:0] way_lines;

  // lookup and replacement
  tag_t      lookup_tag;
  word_sel_t word_sel;
  logic      hit;
  word_t     hit_word;
  way_oh_t   victim_oh;
  logic      refill_done;

  icache_ctrl i_ctrl (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .fetch_req_valid_i ( fetch_req_valid_i ),
    .fetch_req_i       ( fetch_req_i       ),
    .fetch_rsp_ready_i ( fetch_rsp_ready_i ),
    .mem_req_ready_i   ( mem_req_ready_i   ),
    .mem_rtrn_valid_i  ( mem_rtrn_valid_i  ),
    .mem_rtrn_i        ( mem_rtrn_i        ),
    .flush_i           ( flush_i           ),
    .hit_i             ( hit               ),
    .hit_word_i        ( hit_word          ),
    .victim_oh_i       ( victim_oh         ),
    .fetch_req_ready_o ( fetch_req_ready_o ),
    .fetch_rsp_valid_o ( fetch_rsp_valid_o ),
    .fetch_rsp_o       ( fetch_rsp_o       ),
    .mem_req_valid_o   ( mem_req_valid_o   ),
    .mem_req_o         ( mem_req_o         ),
    .miss_o            ( miss_o            ),
    .busy_o            ( busy_o            ),
    .read_en_o         ( rd_en             ),
    .read_set_o        ( rd_set            ),
    .wr_en_o           ( wr_en             ),
    .wr_o              ( wr                ),
    .lookup_tag_o      ( lookup_tag        ),
    .word_sel_o        ( word_sel          ),
    .refill_done_o     ( refill_done       )
  );

  icache_arrays i_arrays (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .read_en_i  ( rd_en     ),
    .read_set_i ( rd_set    ),
    .wr_en_i    ( wr_en     ),
    .wr_i       ( wr        ),
    .tags_o     ( way_tags  ),
    .valid_o    ( way_valid ),
    .lines_o    ( way_lines )
  );

  icache_lookup i_lookup (
    .tags_i       ( way_tags   ),
    .valid_i      ( way_valid  ),
    .lines_i      ( way_lines  ),
    .lookup_tag_i ( lookup_tag ),
    .word_sel_i   ( word_sel   ),
    .hit_o        ( hit        ),
    .hit_word_o   ( hit_word   )
  );

  icache_repl i_repl (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .valid_i       ( way_valid   ),
    .refill_done_i ( refill_done ),
    .victim_oh_o   ( victim_oh   )
  );

endmodule

// ==== tb/icache_ref_model.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_ref_model import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // refill port of the DUT
  input  logic        mem_req_valid_i,
  output logic        mem_req_ready_o,
  input  mem_req_t    mem_req_i,
  output logic        mem_rtrn_valid_o,
  output mem_rtrn_t   mem_rtrn_o,
  // fetch and flush traffic seen by the model
  input  logic        fetch_req_valid_i,
  input  fetch_req_t  fetch_req_i,
  input  logic        flush_i,
  // expectation for the fetch in flight
  output logic        exp_known_o,
  output logic        exp_miss_o,
  // refill bookkeeping, updated at the falling edge
  output int unsigned req_cnt_o,
  output mem_req_t    last_req_o,
  output logic        req_stall_o
);

  // lines refilled since the last flush or reset
  mem_req_t    filled_q [$];
  logic        flush_q;
  logic        fetch_q;
  mem_req_t    fetch_line_q;
  logic        pending;
  int unsigned wait_cnt;
  mem_req_t    pend_line;

  // every word holds its own byte address, inverted
  function automatic line_t line_data(input mem_req_t line);
    line_t d;
    addr_t byte_addr;
    for (int w = 0; w < `ICACHE_LINE_W / `ICACHE_WORD_W; w++) begin
      byte_addr = (addr_t'(line.line_addr) << `ICACHE_OFFSET_W) + addr_t'(4 * w);
      d[w * `ICACHE_WORD_W +: `ICACHE_WORD_W] = ~byte_addr;
    end
    return d;
  endfunction

  function automatic logic was_filled(input mem_req_t line);
    foreach (filled_q[i]) begin
      if (filled_q[i] == line) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // distinct tags refilled into one set
  function automatic int unsigned lines_in_set(input set_idx_t set);
    int unsigned n;
    n = 0;
    foreach (filled_q[i]) begin
      if (set_idx_t'(filled_q[i].line_addr) == set) begin
        n++;
      end
    end
    return n;
  endfunction

  // inputs from the testbench change on the falling edge, so take them here
  always @(posedge clk_i) begin : p_sample
    flush_q               <= flush_i || !rst_ni;
    fetch_q               <= fetch_req_valid_i;
    fetch_line_q.line_addr <= fetch_req_i.addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W];
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory responder and cache content model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_memory
    mem_req_ready_o  = 1'b0;
    mem_rtrn_valid_o = 1'b0;
    mem_rtrn_o       = '0;
    pending          = 1'b0;
    wait_cnt         = 0;
    exp_known_o     <= 1'b1;
    exp_miss_o      <= 1'b0;
    req_cnt_o       <= 0;
    last_req_o      <= '0;
    req_stall_o     <= 1'b0;
    forever begin
      @(negedge clk_i);
      mem_rtrn_valid_o = 1'b0;
      if (flush_q) begin
        filled_q.delete();
      end
      // a line counts as cached while its set has seen at most 4 tags
      if (fetch_q) begin
        exp_miss_o  <= !was_filled(fetch_line_q);
        exp_known_o <= !was_filled(fetch_line_q) ||
                       (lines_in_set(set_idx_t'(fetch_line_q.line_addr)) <= `ICACHE_WAYS);
      end
      // return goes out 1 to 6 cycles after the request
      if (pending) begin
        if (wait_cnt == 0) begin
          mem_rtrn_valid_o = 1'b1;
          mem_rtrn_o.data  = line_data(pend_line);
          pending          = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
      mem_req_ready_o = ($urandom_range(3) != 0);
      req_stall_o    <= mem_req_valid_i && !mem_req_ready_o;
      if (mem_req_valid_i && mem_req_ready_o) begin
        pending     = 1'b1;
        wait_cnt    = $urandom_range(5);
        pend_line   = mem_req_i;
        req_cnt_o  <= req_cnt_o + 1;
        last_req_o <= mem_req_i;
        if (!was_filled(mem_req_i)) begin
          filled_q.push_back(mem_req_i);
        end
      end
    end
  end

endmodule

// ==== tb/icache_tb.sv ====
`timescale 1ns/1ps
`include "icache_consts.svh"

module icache_tb import icache_pkg::*; ();

  localparam int unsigned NUM_FETCH  = 400;
  localparam int unsigned POOL_LINES = 12;
  localparam int unsigned CLK_HALF   = 10;
  localparam int unsigned SEED       = 32'h2b6b_ebb4;

  logic        clk;
  logic        rst_n;
  logic        fetch_req_valid, fetch_req_ready;
  fetch_req_t  fetch_req;
  logic        fetch_rsp_valid, fetch_rsp_ready;
  fetch_rsp_t  fetch_rsp;
  logic        mem_req_valid, mem_req_ready, mem_rtrn_valid;
  mem_req_t    mem_req, last_req;
  mem_rtrn_t   mem_rtrn;
  logic        flush, miss, busy;
  logic        exp_known, exp_miss, req_stall;
  int unsigned req_cnt;
  int unsigned errors, checks, misses_total;
  mem_req_t    pool [POOL_LINES];

  always #(CLK_HALF) clk = ~clk;

  icache_top dut_i (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .fetch_req_valid_i ( fetch_req_valid ),
    .fetch_req_ready_o ( fetch_req_ready ),
    .fetch_req_i       ( fetch_req       ),
    .fetch_rsp_valid_o ( fetch_rsp_valid ),
    .fetch_rsp_ready_i ( fetch_rsp_ready ),
    .fetch_rsp_o       ( fetch_rsp       ),
    .mem_req_valid_o   ( mem_req_valid   ),
    .mem_req_ready_i   ( mem_req_ready   ),
    .mem_req_o         ( mem_req         ),
    .mem_rtrn_valid_i  ( mem_rtrn_valid  ),
    .mem_rtrn_i        ( mem_rtrn        ),
    .flush_i           ( flush           ),
    .miss_o            ( miss            ),
    .busy_o            ( busy            )
  );

  icache_ref_model mem_model_i (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .mem_req_valid_i   ( mem_req_valid   ),
    .mem_req_ready_o   ( mem_req_ready   ),
    .mem_req_i         ( mem_req         ),
    .mem_rtrn_valid_o  ( mem_rtrn_valid  ),
    .mem_rtrn_o        ( mem_rtrn        ),
    .fetch_req_valid_i ( fetch_req_valid ),
    .fetch_req_i       ( fetch_req       ),
    .flush_i           ( flush           ),
    .exp_known_o       ( exp_known       ),
    .exp_miss_o        ( exp_miss        ),
    .req_cnt_o         ( req_cnt         ),
    .last_req_o        ( last_req        ),
    .req_stall_o       ( req_stall       )
  );

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // called on a falling edge, returns once a fetch can be taken
  task automatic wait_for_ready(input string cause);
    int unsigned busy_cycles;
    busy_cycles = 0;
    while (!fetch_req_ready) begin
      if (busy) begin
        busy_cycles++;
      end
      @(negedge clk);
    end
    // one set cleared per cycle
    check_value({"busy_o cycles after ", cause},
                (busy_cycles >= `ICACHE_SETS) ? `ICACHE_SETS : busy_cycles, `ICACHE_SETS);
  endtask

  task automatic flush_cache();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    wait_for_ready("flush");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one fetch, from request to accepted response
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_fetch(input addr_t addr);
    int unsigned cycles, first, misses, base;
    logic        seen, done;
    fetch_rsp_t  held;
    mem_req_t    req_prev;
    fetch_req_valid = 1'b1;
    fetch_req.addr  = addr;
    while (!fetch_req_ready) @(negedge clk);
    // accepted on the rising edge just passed
    @(negedge clk);
    fetch_req_valid = 1'b0;
    base     = req_cnt;
    cycles   = 0;
    first    = 0;
    misses   = 0;
    seen     = 1'b0;
    done     = 1'b0;
    req_prev = mem_req;
    while (!done) begin
      if (miss) begin
        misses++;
      end
      // refill request held while memory stalls
      if (req_stall) begin
        check_value("mem_req_valid_o", mem_req_valid, 1'b1);
        check_value("mem_req_o", mem_req, req_prev);
      end
      req_prev = mem_req;
      if (fetch_rsp_valid) begin
        if (!seen) begin
          seen  = 1'b1;
          first = cycles;
          held  = fetch_rsp;
          check_value("fetch_rsp_o.data", fetch_rsp.data, word_t'(~addr));
          check_value("fetch_rsp_o.addr", fetch_rsp.addr, addr);
        end else begin
          check_value("fetch_rsp_o", fetch_rsp, held);
        end
        fetch_rsp_ready = ($urandom_range(3) != 0);
        done            = fetch_rsp_ready;
      end else begin
        if (seen) begin
          // response withdrawn without a handshake
          check_value("fetch_rsp_valid_o", 1'b0, 1'b1);
          done = 1'b1;
        end
        fetch_rsp_ready = $urandom_range(1);
      end
      @(negedge clk);
      cycles++;
    end
    check_value("fetch_rsp_valid_o", fetch_rsp_valid, 1'b0);
    misses_total += misses;
    if (exp_known) begin
      check_value("miss_o pulses", misses, exp_miss);
      check_value("mem_req_valid_o transfers", req_cnt - base, exp_miss);
      if (!exp_miss) begin
        check_value("fetch_rsp_valid_o delay", first, 2);
      end
    end else begin
      // set may have evicted the line, either answer is legal
      check_value("mem_req_valid_o transfers", req_cnt - base, misses);
      if (misses > 1) begin
        check_value("miss_o pulses", misses, 1);
      end
    end
    if (req_cnt != base) begin
      check_value("mem_req_o.line_addr", last_req.line_addr,
                  addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W]);
    end
  endtask

  initial begin : p_main
    int unsigned s0;
    tag_t        tag_v;
    set_idx_t    set_v;
    addr_t       addr;
    clk             = 1'b0;
    rst_n           = 1'b0;
    fetch_req_valid = 1'b0;
    fetch_req       = '0;
    fetch_rsp_ready = 1'b0;
    flush           = 1'b0;
    errors          = 0;
    checks          = 0;
    misses_total    = 0;
    void'($urandom(SEED));
    // 12 lines spread over 3 sets, tags made distinct by their low bits
    s0 = $urandom_range(15);
    for (int i = 0; i < POOL_LINES; i++) begin
      tag_v   = {20'($urandom), 4'(i)};
      set_v   = set_idx_t'(s0 + 5 * $urandom_range(2));
      pool[i] = '{line_addr: {tag_v, set_v}};
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_for_ready("reset");
    for (int n = 0; n < NUM_FETCH; n++) begin
      if ($urandom_range(24) == 0) begin
        flush_cache();
      end
      addr = {pool[$urandom_range(POOL_LINES - 1)].line_addr, 2'($urandom_range(3)), 2'b00};
      run_fetch(addr);
    end
    $display("fetches %0d, misses %0d, checks %0d, errors %0d",
             NUM_FETCH, misses_total, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // generous bound of 40 cycles per fetch
  initial begin : p_watchdog
    #(NUM_FETCH * 40 * 2 * CLK_HALF);
    $display("timeout: fetches not done after %0d cycles, checks %0d, errors %0d",
             NUM_FETCH * 40, checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hw
hw/icache_pkg.sv
hw/icache_arrays.sv
hw/icache_lookup.sv
hw/icache_repl.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_ref_model.sv
tb/icache_tb.sv
